// File: Makefile
VERILATOR  := verilator
TOP        := tb_vec_unit
FILELIST   := vec_unit.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

// File: logic/vec_pe.sv
`timescale 1ns/10ps

module vec_pe (
    input  logic                     clk,
    input  logic                     n_reset,
    input  vec_pkg::vop_t            op,
    input  vec_pkg::pe_in_t          operands,
    output logic [vec_pkg::vlen-1:0] result
);
    import vec_pkg::*;

    logic [vlen-1:0] res_q;
    logic            acc_q;

    always_ff @(posedge clk, negedge n_reset)
    begin
        if (!n_reset)
        begin
            res_q <= '0;
            acc_q <= 1'b0;
        end
        else
        begin
            case (op)
                op_add:  res_q <= operands.a + operands.b;
                op_sub:  res_q <= operands.a - operands.b;
                // Product for both mul and macc
                default: res_q <= operands.a * operands.b;
            endcase
            acc_q <= (op == op_macc);
        end
    end

    // vd is the vs3 port and points at the write slot one cycle after the
    // sources, so the old destination element is added on the way out
    assign result = acc_q ? res_q + operands.c : res_q;

endmodule

// File: logic/vec_pkg.sv
package vec_pkg;

    // Register file geometry
    localparam int vlen = 32;
    localparam int num_vregs = 32;
    localparam int num_pes = 4;
    localparam int max_vl = 32;
    localparam int vdata_w = vlen * num_pes;

    // Wishbone word addresses
    localparam logic [7:0] reg_cmd = 8'd0;
    localparam logic [7:0] reg_status = 8'd1;
    localparam logic [7:0] reg_win = 8'd32;

    typedef enum logic [1:0] {
        sew_8  = 2'd0,
        sew_16 = 2'd1,
        sew_32 = 2'd2
    } sew_t;

    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_mul  = 3'd2,
        op_macc = 3'd3
    } vop_t;

    // Command word with op in the low bits
    typedef struct packed {
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [4:0] vd;
        logic [5:0] vl;
        sew_t       vsew;
        logic       widen;
        vop_t       op;
    } vcmd_t;

    typedef struct packed {
        logic [vlen-1:0] c;
        logic [vlen-1:0] b;
        logic [vlen-1:0] a;
    } pe_in_t;

    // Destination width is doubled for widening ops
    function automatic sew_t eff_sew(input sew_t w, input logic widen);
        if (widen && w == sew_8)
            return sew_16;
        if (widen && w == sew_16)
            return sew_32;
        return w;
    endfunction

endpackage

// File: logic/vec_sequencer.sv
`timescale 1ns/10ps

module vec_sequencer (
    input  logic            clk,
    input  logic            n_reset,
    input  logic            start,
    input  vec_pkg::vcmd_t  cmd,
    output logic            busy,
    output logic [4:0]      vs1_addr,
    output logic [4:0]      vs2_addr,
    output logic [4:0]      vd_addr,
    output vec_pkg::sew_t   vsew,
    output logic            widening_op,
    output logic            write,
    output logic [1:0]      elements_to_write,
    output vec_pkg::vop_t   op
);
    import vec_pkg::*;

    vcmd_t      cmd_q;
    logic       active;
    logic [2:0] step;
    logic [2:0] last_step;
    logic       is_last;
    logic [4:0] src_stride;
    logic [4:0] dst_stride;
    logic [4:0] vs1_q;
    logic [4:0] vs2_q;
    logic [4:0] vd_q;
    logic       wr_q;
    logic [4:0] wr_addr_q;
    logic [1:0] wr_cnt_q;

    // Index of the last of ceil(vl / 4) steps
    assign last_step = 3'((cmd_q.vl - 6'd1) >> 2);
    assign is_last = step == last_step;
    assign src_stride = 5'd1 << cmd_q.vsew;
    assign dst_stride = 5'd1 << eff_sew(cmd_q.vsew, cmd_q.widen);

    always_ff @(posedge clk, negedge n_reset)
    begin
        if (!n_reset)
        begin
            active <= 1'b0;
            step <= '0;
            wr_q <= 1'b0;
            wr_cnt_q <= '0;
        end
        else
        begin
            if (start)
            begin
                active <= 1'b1;
                step <= '0;
            end
            else if (active)
            begin
                step <= step + 3'd1;
                if (is_last)
                    active <= 1'b0;
            end
            // Write side trails the read side by the PE stage
            wr_q <= active;
            wr_cnt_q <= (active && is_last) ? cmd_q.vl[1:0] : 2'd0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            cmd_q <= cmd;
            vs1_q <= cmd.vs1;
            vs2_q <= cmd.vs2;
            vd_q <= cmd.vd;
        end
        else if (active)
        begin
            vs1_q <= vs1_q + src_stride;
            vs2_q <= vs2_q + src_stride;
            vd_q <= vd_q + dst_stride;
        end
        wr_addr_q <= vd_q;
    end

    assign busy = active || wr_q;
    assign vs1_addr = vs1_q;
    assign vs2_addr = vs2_q;
    assign vd_addr = wr_addr_q;
    assign vsew = cmd_q.vsew;
    assign widening_op = cmd_q.widen;
    assign write = wr_q;
    assign elements_to_write = wr_cnt_q;
    assign op = cmd_q.op;

    // Host waits for idle, and only legal lengths arrive
    a_start_idle: assert property (@(posedge clk) disable iff (!n_reset)
        start |-> !busy && cmd.vl != 6'd0 && cmd.vl <= 6'(max_vl));

endmodule

// File: logic/vec_unit.sv
`timescale 1ns/10ps

module vec_unit (
    input  logic        clk,
    input  logic        n_reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [7:0]  adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack
);
    import vec_pkg::*;

    logic               busy;
    logic               start;
    vcmd_t              cmd;
    logic               grant;
    logic               host_write;
    logic [4:0]         host_addr;
    logic [31:0]        host_data;
    logic [31:0]        host_rdata;

    logic [4:0]         seq_vs1_addr;
    logic [4:0]         seq_vs2_addr;
    logic [4:0]         seq_vd_addr;
    sew_t               seq_vsew;
    logic               seq_widen;
    logic               seq_write;
    logic [1:0]         seq_count;
    vop_t               op;

    logic [4:0]         rf_vs1_addr;
    logic [4:0]         rf_vs2_addr;
    logic [4:0]         rf_vd_addr;
    sew_t               rf_vsew;
    logic               rf_widen;
    logic               rf_write;
    logic [1:0]         rf_count;
    logic [vdata_w-1:0] rf_vd_data;
    logic [vdata_w-1:0] vs1_data;
    logic [vdata_w-1:0] vs2_data;
    logic [vdata_w-1:0] vs3_data;
    logic [vdata_w-1:0] pe_result;

    vec_wb_slave u_slave (
        .clk        (clk),
        .n_reset    (n_reset),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .busy       (busy),
        .start      (start),
        .cmd        (cmd),
        .grant      (grant),
        .host_write (host_write),
        .host_addr  (host_addr),
        .host_data  (host_data),
        .host_rdata (host_rdata)
    );

    vec_sequencer u_seq (
        .clk               (clk),
        .n_reset           (n_reset),
        .start             (start),
        .cmd               (cmd),
        .busy              (busy),
        .vs1_addr          (seq_vs1_addr),
        .vs2_addr          (seq_vs2_addr),
        .vd_addr           (seq_vd_addr),
        .vsew              (seq_vsew),
        .widening_op       (seq_widen),
        .write             (seq_write),
        .elements_to_write (seq_count),
        .op                (op)
    );

    // Host sees the file as plain 32b words with one register per access
    always_comb
    begin
        if (grant)
        begin
            rf_vs1_addr = host_addr;
            rf_vs2_addr = host_addr;
            rf_vd_addr = host_addr;
            rf_vsew = sew_32;
            rf_widen = 1'b0;
            rf_write = host_write;
            rf_count = 2'd1;
            rf_vd_data = {{(vdata_w-32){1'b0}}, host_data};
        end
        else
        begin
            rf_vs1_addr = seq_vs1_addr;
            rf_vs2_addr = seq_vs2_addr;
            rf_vd_addr = seq_vd_addr;
            rf_vsew = seq_vsew;
            rf_widen = seq_widen;
            rf_write = seq_write;
            rf_count = seq_count;
            rf_vd_data = pe_result;
        end
    end

    assign host_rdata = vs1_data[31:0];

    vector_registers u_regs (
        .clk               (clk),
        .n_reset           (n_reset),
        .vs1_addr          (rf_vs1_addr),
        .vs2_addr          (rf_vs2_addr),
        .vd_addr           (rf_vd_addr),
        .vsew              (rf_vsew),
        .widening_op       (rf_widen),
        .write             (rf_write),
        .elements_to_write (rf_count),
        .vd_data           (rf_vd_data),
        .vs1_data          (vs1_data),
        .vs2_data          (vs2_data),
        .vs3_data          (vs3_data)
    );

    for (genvar i = 0; i < num_pes; i++)
    begin : g_pe
        pe_in_t pe_in;

        assign pe_in = '{a: vs1_data[vlen*i +: vlen],
                         b: vs2_data[vlen*i +: vlen],
                         c: vs3_data[vlen*i +: vlen]};

        vec_pe u_pe (
            .clk      (clk),
            .n_reset  (n_reset),
            .op       (op),
            .operands (pe_in),
            .result   (pe_result[vlen*i +: vlen])
        );
    end

endmodule

// File: logic/vec_wb_slave.sv
`timescale 1ns/10ps

module vec_wb_slave (
    input  logic            clk,
    input  logic            n_reset,
    input  logic            cyc,
    input  logic            stb,
    input  logic            we,
    input  logic [7:0]      adr,
    input  logic [31:0]     dat_w,
    output logic [31:0]     dat_r,
    output logic            ack,
    input  logic            busy,
    output logic            start,
    output vec_pkg::vcmd_t  cmd,
    output logic            grant,
    output logic            host_write,
    output logic [4:0]      host_addr,
    output logic [31:0]     host_data,
    input  logic [31:0]     host_rdata
);
    import vec_pkg::*;

    logic req;
    logic accept;
    logic hit_cmd;
    logic hit_status;
    logic hit_win;

    assign req = cyc && stb && !ack;
    assign hit_cmd = adr == reg_cmd;
    assign hit_status = adr == reg_status;
    assign hit_win = adr >= reg_win && adr < reg_win + 8'(num_vregs);

    // Status is always answered while the rest waits until execution ends
    assign accept = req && (hit_status || !busy);

    assign grant = !busy;
    assign host_write = accept && we && hit_win;
    assign host_addr = adr[4:0];
    assign host_data = dat_w;

    always_ff @(posedge clk, negedge n_reset)
    begin
        if (!n_reset)
        begin
            ack <= 1'b0;
            start <= 1'b0;
        end
        else
        begin
            ack <= accept;
            start <= accept && we && hit_cmd;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            if (hit_status)
                dat_r <= {31'b0, busy};
            else if (hit_win)
                dat_r <= host_rdata;
            else
                dat_r <= '0;
            if (we && hit_cmd)
                cmd <= vcmd_t'(dat_w[$bits(vcmd_t)-1:0]);
        end
    end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!n_reset)
        ack |-> cyc && stb);

endmodule

// File: logic/vector_registers.sv
`timescale 1ns/10ps

module vector_registers (
    input  logic                        clk,
    input  logic                        n_reset,
    input  logic [4:0]                  vs1_addr,
    input  logic [4:0]                  vs2_addr,
    input  logic [4:0]                  vd_addr,
    input  vec_pkg::sew_t               vsew,
    input  logic                        widening_op,
    input  logic                        write,
    input  logic [1:0]                  elements_to_write,
    input  logic [vec_pkg::vdata_w-1:0] vd_data,
    output logic [vec_pkg::vdata_w-1:0] vs1_data,
    output logic [vec_pkg::vdata_w-1:0] vs2_data,
    output logic [vec_pkg::vdata_w-1:0] vs3_data
);
    import vec_pkg::*;

    logic [vlen-1:0]      vregs [num_vregs];
    sew_t                 eff_vsew;
    logic [vdata_w-1:0]   vs1_raw;
    logic [vdata_w-1:0]   vs2_raw;
    logic [vdata_w-1:0]   vs3_raw;
    logic [vdata_w-1:0]   wr_packed;
    logic [vdata_w/8-1:0] byte_en;
    logic [2:0]           n_elems;
    logic [4:0]           n_bytes;

    // Group members are found by setting the low address bits, so bases of
    // 16b groups must be even and bases of 32b groups a multiple of four
    function automatic logic [4:0] grp_addr(input logic [4:0] base, input int idx);
        return {base[4:2], base[1:0] | 2'(idx)};
    endfunction

    // Spread packed elements into zero padded 32b lanes with one lane per PE
    function automatic logic [vdata_w-1:0] pad_lanes(input logic [vdata_w-1:0] raw,
                                                     input sew_t w);
        logic [vdata_w-1:0] lanes;
        lanes = '0;
        for (int e = 0; e < num_pes; e++)
        begin
            case (w)
                sew_8:   lanes[vlen*e +: 8] = raw[8*e +: 8];
                sew_16:  lanes[vlen*e +: 16] = raw[16*e +: 16];
                sew_32:  lanes[vlen*e +: vlen] = raw[vlen*e +: vlen];
                default: lanes[vlen*e +: vlen] = '0;
            endcase
        end
        return lanes;
    endfunction

    // Inverse of pad_lanes that drops the upper bits of each lane
    function automatic logic [vdata_w-1:0] strip_lanes(input logic [vdata_w-1:0] lanes,
                                                       input sew_t w);
        logic [vdata_w-1:0] raw;
        raw = '0;
        for (int e = 0; e < num_pes; e++)
        begin
            case (w)
                sew_8:   raw[8*e +: 8] = lanes[vlen*e +: 8];
                sew_16:  raw[16*e +: 16] = lanes[vlen*e +: 16];
                sew_32:  raw[vlen*e +: vlen] = lanes[vlen*e +: vlen];
                default: raw[vlen*e +: vlen] = '0;
            endcase
        end
        return raw;
    endfunction

    assign eff_vsew = eff_sew(vsew, widening_op);

    // Four registers per operand keep all PEs fed at 32b elements.
    // vd doubles as the vs3 read address
    for (genvar r = 0; r < num_pes; r++)
    begin : g_rd
        assign vs1_raw[vlen*r +: vlen] = vregs[grp_addr(vs1_addr, r)];
        assign vs2_raw[vlen*r +: vlen] = vregs[grp_addr(vs2_addr, r)];
        assign vs3_raw[vlen*r +: vlen] = vregs[grp_addr(vd_addr, r)];
    end

    assign vs1_data = pad_lanes(vs1_raw, vsew);
    assign vs2_data = pad_lanes(vs2_raw, vsew);
    // Accumulator of a widening op is already at the wide width
    assign vs3_data = pad_lanes(vs3_raw, eff_vsew);

    assign wr_packed = strip_lanes(vd_data, eff_vsew);

    // A count of zero means a full step of four elements
    assign n_elems = (elements_to_write == 2'd0) ? 3'd4 : {1'b0, elements_to_write};
    assign n_bytes = 5'(n_elems) << eff_vsew;

    always_comb
    begin
        for (int b = 0; b < vdata_w/8; b++)
            byte_en[b] = 5'(b) < n_bytes;
    end

    always_ff @(posedge clk, negedge n_reset)
    begin
        if (!n_reset)
        begin
            for (int r = 0; r < num_vregs; r++)
                vregs[r] <= '0;
        end
        // v0 holds the mask and is never written
        else if (write && vd_addr != 5'd0)
        begin
            for (int b = 0; b < vdata_w/8; b++)
            begin
                if (byte_en[b])
                    vregs[grp_addr(vd_addr, b / (vlen/8))][8*(b % (vlen/8)) +: 8]
                        <= wr_packed[8*b +: 8];
            end
        end
    end

    // Sequencer and host together must never ask for a 64b destination
    a_no_wide_sew32: assert property (@(posedge clk) disable iff (!n_reset)
        widening_op |-> vsew != sew_32);

endmodule

// File: sim/tb_vec_unit.sv
`timescale 1ns/10ps

module tb_vec_unit;
    import vec_pkg::*;

    localparam int ack_limit = 20;
    localparam int busy_limit = 40;

    logic        clk;
    logic        n_reset;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;

    // Shadow register file where byte 4n+j is byte j of register n
    logic [7:0]  shadow [4*num_vregs];
    logic        exp_valid;
    logic [31:0] exp_data;
    string       test_name;
    int          seed;

    vec_unit uut (
        .clk     (clk),
        .n_reset (n_reset),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .dat_w   (dat_w),
        .dat_r   (dat_r),
        .ack     (ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_now(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // Register window reads are compared with the shadow model while armed
    a_read_data: assert property (@(posedge clk) disable iff (!n_reset)
        ack && exp_valid |-> dat_r == exp_data)
        else fail_now($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                test_name, exp_data, dat_r));

    a_ack_pulse: assert property (@(posedge clk) disable iff (!n_reset)
        ack |=> !ack)
        else fail_now("ack stayed high for more than one cycle");

    function automatic logic [31:0] get_elem(input int base, input int idx, input int nbytes);
        logic [31:0] v;
        v = '0;
        for (int j = 0; j < nbytes; j++)
            v[8*j +: 8] = shadow[4*base + idx*nbytes + j];
        return v;
    endfunction

    // Only the low nbytes of the value land in the register
    function automatic void set_elem(input int base, input int idx, input int nbytes,
                                     input logic [31:0] v);
        for (int j = 0; j < nbytes; j++)
            shadow[4*base + idx*nbytes + j] = v[8*j +: 8];
    endfunction

    function automatic logic [31:0] shadow_word(input int n);
        return {shadow[4*n+3], shadow[4*n+2], shadow[4*n+1], shadow[4*n]};
    endfunction

    // Applies one instruction element by element on unsigned values
    // Results wrap to the destination width
    function automatic void apply_model(input vop_t op, input logic widen, input sew_t sew,
                                        input int vl, input int vd, input int vs1,
                                        input int vs2);
        int          w;
        int          ew;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] r;
        w = 1 << int'(sew);
        ew = widen ? 2 * w : w;
        for (int i = 0; i < vl; i++)
        begin
            a = get_elem(vs1, i, w);
            b = get_elem(vs2, i, w);
            c = get_elem(vd, i, ew);
            case (op)
                op_add:  r = a + b;
                op_sub:  r = a - b;
                op_mul:  r = a * b;
                default: r = c + a * b;
            endcase
            set_elem(vd, i, ew, r);
        end
    endfunction

    task automatic wb_cycle(input logic wr, input logic [7:0] a, input logic [31:0] d,
                            output logic [31:0] q);
        int waited;
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= wr;
        adr <= a;
        dat_w <= d;
        waited = 0;
        @(negedge clk);
        while (!ack)
        begin
            if (waited == ack_limit)
                fail_now($sformatf("no ack for word address %0d within %0d cycles",
                                   a, ack_limit));
            else
            begin
                @(negedge clk);
                waited++;
            end
        end
        q = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
    endtask

    task automatic reg_write(input int n, input logic [31:0] d);
        logic [31:0] q;
        wb_cycle(1'b1, 8'(int'(reg_win) + n), d, q);
        // v0 is write protected
        if (n != 0)
            set_elem(n, 0, 4, d);
    endtask

    task automatic reg_read(input int n);
        logic [31:0] q;
        exp_data = shadow_word(n);
        exp_valid = 1'b1;
        wb_cycle(1'b0, 8'(int'(reg_win) + n), 32'd0, q);
        exp_valid = 1'b0;
    endtask

    task automatic read_busy(output logic b);
        logic [31:0] q;
        wb_cycle(1'b0, reg_status, 32'd0, q);
        b = q[0];
    endtask

    task automatic wait_idle();
        logic b;
        int   polls;
        polls = 0;
        read_busy(b);
        while (b)
        begin
            if (polls == busy_limit)
                fail_now($sformatf("busy still high after %0d status polls", busy_limit));
            else
            begin
                read_busy(b);
                polls++;
            end
        end
    endtask

    task automatic check_all();
        for (int n = 0; n < num_vregs; n++)
            reg_read(n);
    endtask

    task automatic issue(input vop_t op, input logic widen, input sew_t sew, input int vl,
                         input int vd, input int vs1, input int vs2);
        vcmd_t       cmd;
        logic [31:0] q;
        cmd.op = op;
        cmd.widen = widen;
        cmd.vsew = sew;
        cmd.vl = 6'(vl);
        cmd.vd = 5'(vd);
        cmd.vs1 = 5'(vs1);
        cmd.vs2 = 5'(vs2);
        wb_cycle(1'b1, reg_cmd, 32'(cmd), q);
        apply_model(op, widen, sew, vl, vd, vs1, vs2);
    endtask

    initial
    begin
        logic bsy;
        seed = 53075;
        n_reset = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        exp_valid = 1'b0;
        exp_data = '0;
        for (int i = 0; i < 4*num_vregs; i++)
            shadow[i] = 8'd0;
        repeat (5) @(posedge clk);
        n_reset <= 1'b1;

        test_name = "reset_zero";
        check_all();

        test_name = "host_rw";
        for (int n = 1; n < num_vregs; n++)
            reg_write(n, 32'($random(seed)));
        reg_write(0, 32'($random(seed)));
        check_all();

        // Groups of 32b elements start on a multiple of four
        test_name = "vadd_32";
        issue(op_add, 1'b0, sew_32, 8, 24, 8, 16);
        wait_idle();
        check_all();

        test_name = "vsub_32";
        issue(op_sub, 1'b0, sew_32, 8, 24, 8, 16);
        wait_idle();
        check_all();

        test_name = "vmul_8";
        issue(op_mul, 1'b0, sew_8, 6, 5, 1, 3);
        wait_idle();
        check_all();

        test_name = "vmacc_16";
        issue(op_macc, 1'b0, sew_16, 7, 16, 8, 12);
        wait_idle();
        check_all();

        test_name = "vwmul_8";
        issue(op_mul, 1'b1, sew_8, 8, 24, 20, 22);
        wait_idle();
        check_all();

        // Eight steps keep the unit busy long enough for two host accesses
        test_name = "busy_read";
        issue(op_add, 1'b0, sew_8, 32, 17, 1, 9);
        read_busy(bsy);
        assert (bsy)
            else fail_now($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                    test_name, 1'b1, bsy));
        reg_read(24);
        wait_idle();
        check_all();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: vec_unit.f
logic/vec_pkg.sv
logic/vector_registers.sv
logic/vec_pe.sv
logic/vec_sequencer.sv
logic/vec_wb_slave.sv
logic/vec_unit.sv
sim/tb_vec_unit.sv
